//--- verilog/btb_consts.svh
`ifndef BTB_CONSTS_SVH
`define BTB_CONSTS_SVH

// sizes of the branch target buffer

// number of fully associative entries
`define BTB_ENTRIES 64

// width of an instruction pointer and of a predicted target
`define BTB_EIP_W 32

// fetch-line pointer width
// upper bits of a 32-bit fetch address, 16-byte lines
`define BTB_FIP_W 28

`endif

//--- verilog/btb_pkg.sv
`default_nettype none

`include "btb_consts.svh"

// shared types for the branch target buffer
package btb_pkg;

    // instruction pointer or predicted target address
    // also used as the stored tag, full EIP compare
    typedef logic [`BTB_EIP_W-1:0] eip_t;

    // fetch-line pointer
    // one for the even line, one for the odd line
    typedef logic [`BTB_FIP_W-1:0] fip_t;

    // one bit per entry
    // write enables, lookup matches, update matches,
    // and the one-hot victim pointer
    typedef logic [`BTB_ENTRIES-1:0] entry_vec_t;

    // per-entry payload buses are built as packed arrays of these,
    // e.g. eip_t [`BTB_ENTRIES-1:0], indexed by entry number

endpackage

`default_nettype wire

//--- verilog/btb_update_ctrl.sv
`default_nettype none

`include "btb_consts.svh"

// writeback side of the buffer
// four-phase req/ack, one write strobe per request
module btb_update_ctrl (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               upd_req,
    // valid entries whose tag equals upd_eip
    input  wire btb_pkg::entry_vec_t upd_hit_vec,
    output logic                    upd_ack,
    // one-hot, at most one bit per request
    output btb_pkg::entry_vec_t     wr_en
);

    import btb_pkg::*;

    // one-hot round-robin victim pointer
    entry_vec_t victim_q;
    // pointer after one rotation step
    entry_vec_t victim_next;
    // slot picked for this request
    entry_vec_t slot_sel;
    // new request seen at this edge
    logic       upd_start;
    // branch EIP already held by some entry
    logic       upd_hit;

    // req high and ack still low
    // marks the single cycle that writes
    assign upd_start = upd_req & ~upd_ack;

    // any entry already holds this EIP
    assign upd_hit = |upd_hit_vec;

    // rotate left by one, entry 63 wraps to entry 0
    assign victim_next = {victim_q[`BTB_ENTRIES-2:0], victim_q[`BTB_ENTRIES-1]};

    // rewrite in place on a hit
    // otherwise allocate the slot under the pointer
    assign slot_sel = upd_hit ? upd_hit_vec : victim_q;

    // strobe only in the start cycle
    // a long req does not write twice since ack is already up
    assign wr_en = upd_start ? slot_sel : '0;

    // ack register
    // rises at the edge that writes, holds while req holds,
    // falls one edge after req drops
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            upd_ack <= 1'b0;
        end else if (upd_start) begin
            upd_ack <= 1'b1;
        end else if (!upd_req) begin
            upd_ack <= 1'b0;
        end
    end

    // victim pointer
    // starts at entry 0
    // moves only when a new slot is taken
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            victim_q <= entry_vec_t'(1);
        end else if (upd_start && !upd_hit) begin
            victim_q <= victim_next;
        end
    end

    // in-place rewrites leave the pointer alone, so
    // the oldest allocation is still the next to go

endmodule

`default_nettype wire

//--- verilog/btb_entry.sv
`default_nettype none

// one fully associative entry
// valid, full EIP tag, target and both line pointers
module btb_entry (
    input  wire logic          clk,
    input  wire logic          arst_n,
    // load strobe from the update controller
    input  wire logic          wr,
    input  wire btb_pkg::eip_t wr_eip,
    input  wire btb_pkg::eip_t wr_target,
    input  wire btb_pkg::fip_t wr_fip_e,
    input  wire btb_pkg::fip_t wr_fip_o,
    // fetch address, compared every cycle
    input  wire btb_pkg::eip_t lookup_eip,
    // writeback address, compared for in-place rewrite
    input  wire btb_pkg::eip_t upd_eip,
    output logic               lk_match,
    output logic               upd_match,
    output btb_pkg::eip_t      target,
    output btb_pkg::fip_t      fip_e,
    output btb_pkg::fip_t      fip_o
);

    import btb_pkg::*;

    logic valid_q;
    eip_t tag_q;
    eip_t target_q;
    fip_t fip_e_q;
    fip_t fip_o_q;

    // valid goes up on first write, only reset clears it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (wr) begin
            valid_q <= 1'b1;
        end
    end

    // payload, all fields load together
    // contents of an invalid entry never reach the selector
    always_ff @(posedge clk) begin
        if (wr) begin
            tag_q    <= wr_eip;
            target_q <= wr_target;
            fip_e_q  <= wr_fip_e;
            fip_o_q  <= wr_fip_o;
        end
    end

    // tag compares, both qualified by valid
    assign lk_match  = valid_q & (tag_q == lookup_eip);
    assign upd_match = valid_q & (tag_q == upd_eip);

    // payload out to the hit selector
    assign target = target_q;
    assign fip_e  = fip_e_q;
    assign fip_o  = fip_o_q;

endmodule

`default_nettype wire

//--- verilog/btb_hit_select.sv
`default_nettype none

`include "btb_consts.svh"

// lookup result
// AND-OR select across all entries, purely combinational
module btb_hit_select (
    // per-entry valid tag match on the fetch EIP
    input  wire btb_pkg::entry_vec_t                     lk_match_vec,
    // per-entry payload, index i is entry i
    input  wire btb_pkg::eip_t [`BTB_ENTRIES-1:0] target_flat,
    input  wire btb_pkg::fip_t [`BTB_ENTRIES-1:0] fip_e_flat,
    input  wire btb_pkg::fip_t [`BTB_ENTRIES-1:0] fip_o_flat,
    output logic                                        hit,
    output btb_pkg::eip_t                               target,
    output btb_pkg::fip_t                               fip_e,
    output btb_pkg::fip_t                               fip_o
);

    import btb_pkg::*;

    // accumulated selections
    eip_t sel_target;
    fip_t sel_fip_e;
    fip_t sel_fip_o;

    // any matching entry
    // at most one can match, the controller never
    // allocates an EIP that is already present
    assign hit = |lk_match_vec;

    // mask each entry by its match bit and OR them together
    // with no match everything stays zero
    always_comb begin
        sel_target = '0;
        sel_fip_e  = '0;
        sel_fip_o  = '0;
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            // replicate the match bit over the field width
            sel_target = sel_target | (target_flat[i] & {`BTB_EIP_W{lk_match_vec[i]}});
            sel_fip_e  = sel_fip_e  | (fip_e_flat[i]  & {`BTB_FIP_W{lk_match_vec[i]}});
            sel_fip_o  = sel_fip_o  | (fip_o_flat[i]  & {`BTB_FIP_W{lk_match_vec[i]}});
        end
    end

    // selected payload to fetch
    assign target = sel_target;
    assign fip_e  = sel_fip_e;
    assign fip_o  = sel_fip_o;

    // one-hot select means the OR tree never merges
    // two payloads, so no priority encoder is needed

endmodule

`default_nettype wire

//--- verilog/branch_target_buffer.sv
`default_nettype none

`include "btb_consts.svh"

// branch target buffer for fetch
// 64 entries, fully associative, round-robin replacement
module branch_target_buffer (
    input  wire logic          clk,
    input  wire logic          arst_n,
    // fetch side, answered in the same cycle
    input  wire btb_pkg::eip_t lookup_eip,
    // writeback side, four-phase handshake
    input  wire logic          upd_req,
    input  wire btb_pkg::eip_t upd_eip,
    input  wire btb_pkg::eip_t upd_target,
    input  wire btb_pkg::fip_t upd_fip_e,
    input  wire btb_pkg::fip_t upd_fip_o,
    output logic               upd_ack,
    // prediction back to fetch
    output logic               lookup_hit,
    output btb_pkg::eip_t      lookup_target,
    output btb_pkg::fip_t      lookup_fip_e,
    output btb_pkg::fip_t      lookup_fip_o
);

    import btb_pkg::*;

    // write strobes, one-hot per request
    entry_vec_t wr_en;
    // entries already holding upd_eip
    entry_vec_t upd_match;
    // entries holding lookup_eip
    entry_vec_t lk_match;

    // payload of every entry, gathered for the selector
    eip_t [`BTB_ENTRIES-1:0] target_flat;
    fip_t [`BTB_ENTRIES-1:0] fip_e_flat;
    fip_t [`BTB_ENTRIES-1:0] fip_o_flat;

    // handshake and slot choice
    btb_update_ctrl i_btb_update_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .upd_req     (upd_req),
        .upd_hit_vec (upd_match),
        .upd_ack     (upd_ack),
        .wr_en       (wr_en)
    );

    // entry array
    // every entry sees the same write data and both compare addresses
    for (genvar i = 0; i < `BTB_ENTRIES; i++) begin : g_entry
        btb_entry i_btb_entry (
            .clk        (clk),
            .arst_n     (arst_n),
            .wr         (wr_en[i]),
            .wr_eip     (upd_eip),
            .wr_target  (upd_target),
            .wr_fip_e   (upd_fip_e),
            .wr_fip_o   (upd_fip_o),
            .lookup_eip (lookup_eip),
            .upd_eip    (upd_eip),
            .lk_match   (lk_match[i]),
            .upd_match  (upd_match[i]),
            .target     (target_flat[i]),
            .fip_e      (fip_e_flat[i]),
            .fip_o      (fip_o_flat[i])
        );
    end

    // hit or miss, and the selected payload
    btb_hit_select i_btb_hit_select (
        .lk_match_vec (lk_match),
        .target_flat  (target_flat),
        .fip_e_flat   (fip_e_flat),
        .fip_o_flat   (fip_o_flat),
        .hit          (lookup_hit),
        .target       (lookup_target),
        .fip_e        (lookup_fip_e),
        .fip_o        (lookup_fip_o)
    );

endmodule

`default_nettype wire

//--- dv/btb_tb.sv
`default_nettype none

`include "btb_consts.svh"

// testbench for the branch target buffer
// replays dv/btb_patterns.txt and checks random bursts against a model
module btb_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import btb_pkg::*;

    // one parsed line of the pattern file
    typedef struct {
        byte         op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        int          e;
        int          line_no;
    } pattern_t;

    // what the model keeps per EIP
    typedef struct packed {
        eip_t target;
        fip_t fip_e;
        fip_t fip_o;
    } payload_t;

    logic clk = 1'b0;
    logic arst_n;
    eip_t lookup_eip;
    logic upd_req;
    eip_t upd_eip;
    eip_t upd_target;
    fip_t upd_fip_e;
    fip_t upd_fip_o;
    logic upd_ack;
    logic lookup_hit;
    eip_t lookup_target;
    fip_t lookup_fip_e;
    fip_t lookup_fip_o;

    pattern_t patterns[$];
    // reference model as a map plus allocation order
    // oldest allocation is the round-robin victim
    payload_t model_map[eip_t];
    eip_t     model_order[$];

    int   seed;
    int   error_count = 0;
    int   check_count = 0;
    int   handshake_errors = 0;
    int   cycle_count = 0;
    int   cycle_limit = 1000;
    logic req_at_edge = 1'b0;

    branch_target_buffer i_branch_target_buffer (
        .clk           (clk),
        .arst_n        (arst_n),
        .lookup_eip    (lookup_eip),
        .upd_req       (upd_req),
        .upd_eip       (upd_eip),
        .upd_target    (upd_target),
        .upd_fip_e     (upd_fip_e),
        .upd_fip_o     (upd_fip_o),
        .upd_ack       (upd_ack),
        .lookup_hit    (lookup_hit),
        .lookup_target (lookup_target),
        .lookup_fip_e  (lookup_fip_e),
        .lookup_fip_o  (lookup_fip_o)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // run limit set from the pattern count
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    // four-phase rule says ack one edge later equals req at that edge
    always @(posedge clk) begin
        req_at_edge <= upd_req;
    end

    always @(negedge clk) begin
        assert (upd_ack === req_at_edge) else begin
            $display("handshake error at %0d ns: upd_ack is %b one edge after upd_req was %b",
                     $time, upd_ack, req_at_edge);
            handshake_errors++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("FAIL %0d ns %s expected %h got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    // rewrite in place or else evict the oldest allocation
    function automatic void model_update(input eip_t eip, input payload_t pay);
        eip_t victim;
        if (!model_map.exists(eip)) begin
            if (model_order.size() == `BTB_ENTRIES) begin
                victim = model_order.pop_front();
                model_map.delete(victim);
            end
            model_order.push_back(eip);
        end
        model_map[eip] = pay;
    endfunction

    // a miss gives an all-zero payload like the AND-OR select
    function automatic void model_expect(input eip_t eip, output logic hit,
                                         output payload_t pay);
        hit = model_map.exists(eip);
        pay = hit ? model_map[eip] : '0;
    endfunction

    // called at a falling edge and returns at one with ack low
    task automatic send_update(input eip_t eip, input eip_t target, input fip_t fip_e,
                               input fip_t fip_o, input int hold);
        int waited;
        upd_eip    = eip;
        upd_target = target;
        upd_fip_e  = fip_e;
        upd_fip_o  = fip_o;
        upd_req    = 1'b1;
        @(negedge clk);
        waited = 1;
        while (upd_ack !== 1'b1 && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        check_count++;
        assert (upd_ack === 1'b1) else begin
            $display("upd_ack never rose for the update of EIP %h", eip);
            error_count++;
        end
        // long req still writes only once
        repeat (hold) @(negedge clk);
        upd_req = 1'b0;
        @(negedge clk);
        waited = 1;
        while (upd_ack !== 1'b0 && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        check_count++;
        assert (upd_ack === 1'b0) else begin
            $display("upd_ack stayed high after upd_req fell for EIP %h", eip);
            error_count++;
        end
        model_update(eip, {target, fip_e, fip_o});
    endtask

    // outputs are combinational and sampled one falling edge later
    task automatic compare_lookup(input eip_t eip, input logic exp_hit, input eip_t exp_target,
                                  input fip_t exp_fip_e, input fip_t exp_fip_o);
        lookup_eip = eip;
        @(negedge clk);
        check_value("lookup_hit", 32'(exp_hit), 32'(lookup_hit));
        check_value("lookup_target", exp_target, lookup_target);
        check_value("lookup_fip_e", 32'(exp_fip_e), 32'(lookup_fip_e));
        check_value("lookup_fip_o", 32'(exp_fip_o), 32'(lookup_fip_o));
    endtask

    // every EIP the model holds must still hit with its payload
    task automatic sweep_lookups();
        foreach (model_map[key]) begin
            compare_lookup(key, 1'b1, model_map[key].target, model_map[key].fip_e,
                           model_map[key].fip_o);
        end
    endtask

    // EIPs step by one 16-byte line with the payload derived from the EIP
    task automatic fill_entries(input eip_t base, input int count);
        eip_t eip;
        eip_t target;
        for (int k = 0; k < count; k++) begin
            eip    = base + 32'(k) * 32'h10;
            target = eip + 32'h100;
            send_update(eip, target, target[31:4], target[31:4] + 28'd1, 0);
        end
    endtask

    // small pool so both rewrites and allocations happen
    task automatic random_burst(input eip_t base, input int ops, input int pool);
        int unsigned pick;
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        eip_t        eip;
        logic        m_hit;
        payload_t    m_pay;
        for (int n = 0; n < ops; n++) begin
            pick  = $unsigned($random(seed)) % $unsigned(pool);
            eip   = base + pick * 32'h10;
            rnd_a = $random(seed);
            if (rnd_a[0]) begin
                rnd_b = $random(seed);
                send_update(eip, rnd_b, rnd_a[31:4], rnd_b[31:4] ^ rnd_a[27:0],
                            int'(rnd_a[2:1]));
            end else begin
                model_expect(eip, m_hit, m_pay);
                compare_lookup(eip, m_hit, m_pay.target, m_pay.fip_e, m_pay.fip_o);
            end
        end
    endtask

    // skips comment lines starting with # and blank lines
    task automatic read_patterns();
        int          fd;
        int          n;
        int          line_no;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        int          e;
        pattern_t    p;
        fd = $fopen("dv/btb_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file dv/btb_patterns.txt");
            error_count++;
            return;
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (n == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %h %h %h %h %d", op, a, b, c, d, e);
            if (n != 6) begin
                $display("pattern file line %0d cannot be parsed", line_no);
                error_count++;
                continue;
            end
            p = '{op, a, b, c, d, e, line_no};
            patterns.push_back(p);
        end
        $fclose(fd);
    endtask

    task automatic run_pattern(input pattern_t p);
        logic     m_hit;
        payload_t m_pay;
        case (p.op)
            "U": send_update(p.a, p.b, p.c[27:0], p.d[27:0], p.e);
            "L": begin
                // directed expectation must agree with the model too
                model_expect(p.a, m_hit, m_pay);
                assert (m_hit == (p.e != 0) &&
                        (!m_hit || m_pay == {p.b, p.c[27:0], p.d[27:0]})) else begin
                    $display("pattern line %0d disagrees with the reference model", p.line_no);
                    error_count++;
                end
                compare_lookup(p.a, p.e != 0, p.b, p.c[27:0], p.d[27:0]);
            end
            "F": begin
                fill_entries(p.a, int'(p.b));
                sweep_lookups();
            end
            "R": random_burst(p.a, int'(p.b), int'(p.c));
            default: begin
                $display("pattern line %0d has an unknown opcode", p.line_no);
                error_count++;
            end
        endcase
    endtask

    initial begin
        int errors_before;
        arst_n     = 1'b0;
        lookup_eip = '0;
        upd_req    = 1'b0;
        upd_eip    = '0;
        upd_target = '0;
        upd_fip_e  = '0;
        upd_fip_o  = '0;
        seed       = 32'h4e6c6343;
        read_patterns();
        // 20 per line plus 400 per fill or burst plus 200 for reset and margin
        cycle_limit = 200;
        foreach (patterns[i]) begin
            cycle_limit += 20;
            if (patterns[i].op == "R" || patterns[i].op == "F") begin
                cycle_limit += 400;
            end
        end
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_value("upd_ack", 32'(1'b0), 32'(upd_ack));
        foreach (patterns[i]) begin
            errors_before = error_count + handshake_errors;
            run_pattern(patterns[i]);
            $display("line %0d %c %h: %s", patterns[i].line_no, patterns[i].op, patterns[i].a,
                     (error_count + handshake_errors == errors_before) ? "ok" : "failed");
        end
        $display("done: %0d patterns, %0d checks, %0d errors, %0d handshake errors",
                 patterns.size(), check_count, error_count, handshake_errors);
        if (error_count + handshake_errors == 0 && patterns.size() > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- branch_target_buffer.f
+incdir+verilog
verilog/btb_pkg.sv
verilog/btb_update_ctrl.sv
verilog/btb_entry.sv
verilog/btb_hit_select.sv
verilog/branch_target_buffer.sv
dv/btb_tb.sv

//--- Makefile
# Verilator flow for the branch target buffer

FILELIST = branch_target_buffer.f

.PHONY: all lint sim clean

all: sim

# RTL only, full warning set
lint:
	verilator --lint-only -Wall --timing --top-module branch_target_buffer -f $(FILELIST)

obj_dir/Vbtb_tb: $(FILELIST) verilog/*.sv verilog/*.svh dv/btb_tb.sv
	verilator --binary --timing --assert --top-module btb_tb -f $(FILELIST)

# exit status comes from grep, so a missing pass line fails the target
sim: obj_dir/Vbtb_tb dv/btb_patterns.txt
	./obj_dir/Vbtb_tb | tee /dev/stderr | grep -qx 'TEST PASS'

clean:
	rm -rf obj_dir

//--- dv/btb_patterns.txt
# columns: op eip target fip_e fip_o last, all hex except last (decimal)
# U update, last = extra cycles upd_req stays high after upd_ack
# L lookup, last = expected hit, payload is zero on a miss
# F fill, eip = first EIP, target = count, EIPs step by 0x10,
#   payload target = eip + 0x100, fip_e = target >> 4, fip_o = fip_e + 1
# R random burst, eip = pool base, target = operations, fip_e = pool size
# reset state, everything misses
L 00000000 00000000 0000000 0000000 0
L 00401000 00000000 0000000 0000000 0
L fffffff0 00000000 0000000 0000000 0
L 7fff1234 00000000 0000000 0000000 0
# one install, exact payload back, neighbors miss
U 00401000 00402340 0040234 0040235 0
L 00401000 00402340 0040234 0040235 1
L 00401004 00000000 0000000 0000000 0
L 00400ff0 00000000 0000000 0000000 0
# in-place overwrite with upd_req held long
U 00401000 00405670 0040567 0040568 12
L 00401000 00405670 0040567 0040568 1
L 00401010 00000000 0000000 0000000 0
# 63 more distinct installs, nothing evicted
F 10000000 0000003f 0000000 0000000 0
L 00401000 00405670 0040567 0040568 1
L 10000000 10000100 1000010 1000011 1
L 100001f0 100002f0 100002f 1000030 1
L 100003e0 100004e0 100004e 100004f 1
L 100003f0 00000000 0000000 0000000 0
# 65th install evicts the first one only
U 20000000 20000100 2000010 2000011 3
L 00401000 00000000 0000000 0000000 0
L 20000000 20000100 2000010 2000011 1
L 10000000 10000100 1000010 1000011 1
L 10000010 10000110 1000011 1000012 1
L 100003e0 100004e0 100004e 100004f 1
# 66th install evicts the second
U 20000010 20000110 2000011 2000012 0
L 10000000 00000000 0000000 0000000 0
L 10000010 10000110 1000011 1000012 1
L 20000000 20000100 2000010 2000011 1
L 20000010 20000110 2000011 2000012 1
# rewrite leaves the victim pointer, next allocation takes the third slot
U 10000020 30000000 3000000 3000001 0
U 20000020 20000120 2000012 2000013 0
L 10000010 00000000 0000000 0000000 0
L 10000020 30000000 3000000 3000001 1
L 20000020 20000120 2000012 2000013 1
L 10000030 10000130 1000013 1000014 1
# random mix over two pools
R 10000000 00000064 0000060 0000000 0
R 20000000 00000064 0000050 0000000 0
L 00401000 00000000 0000000 0000000 0
L 7fff1234 00000000 0000000 0000000 0
